// File: hdl/usb_ep_pkg.sv
`default_nettype none

package usb_ep_pkg;

    // Transfer kind of the endpoint
    // Only bulk and interrupt endpoints follow the DATA0/DATA1 toggle sequence
    typedef enum logic [1:0] {
        BULK        = 2'd0,
        INTERRUPT   = 2'd1,
        ISOCHRONOUS = 2'd2
    } ep_type_e;

    // Static endpoint setup, chosen at the top level
    // The address width sets the FIFO depth to 2**addr_wid bytes
    typedef struct packed {
        ep_type_e   ep_type;
        logic [3:0] addr_wid;
    } endpoint_config_t;

    // Bulk endpoint with a 16 byte FIFO
    localparam endpoint_config_t EP_CONF_DEFAULT = '{ep_type: BULK, addr_wid: 4'd4};

    // PID bytes as they come out of the SIE, PID nibble in the low bits
    // The upper nibble is the ones complement check field
    localparam logic [7:0] PID_DATA0 = 8'hC3;
    localparam logic [7:0] PID_DATA1 = 8'h4B;
    localparam logic [7:0] PID_ACK   = 8'hD2;

    // Bit 3 of a data PID is set for DATA1 and clear for DATA0
    // The tracker forwards PID bits [3:2] so this bit lands at index 1 of the token
    localparam int DATA_TOGGLE_BIT = 3;

    // One received byte from the serial interface engine
    // eop marks the last byte of the packet, or comes alone after it
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       eop;
    } rx_byte_t;

    // Fill side transaction end
    // done is a one cycle strobe, success is only looked at together with done
    typedef struct packed {
        logic done;
        logic success;
    } fill_ctrl_t;

    // Pop side request from device logic
    // pop takes one byte, done with success keeps what was read
    typedef struct packed {
        logic pop;
        logic done;
        logic success;
    } pop_ctrl_t;

    // Handshake answer to the host
    typedef struct packed {
        logic       valid;
        logic [7:0] pid;
    } ep_resp_t;

endpackage

`default_nettype wire

// File: hdl/usb_packet_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module usb_packet_tracker (
    input  logic                 clk12_i,
    input  logic                 rst_n_i,
    input  usb_ep_pkg::rx_byte_t rx_i,
    input  logic                 pkt_start_i,
    output logic                 got_start_o,
    output logic [1:0]           token_o,
    output logic                 byte_is_data_o,
    output logic [7:0]           data_o,
    output logic                 data_valid_o
);
    import usb_ep_pkg::*;

    // A start was flagged but its PID byte has not shown up yet
    logic pid_wait_q;
    // Between the PID byte and the end of packet
    logic in_packet_q;
    // The next valid byte is the PID
    logic expect_pid;

    assign expect_pid = pkt_start_i || pid_wait_q;

    // Byte payload just follows the stream with one cycle of delay
    always_ff @(posedge clk12_i) begin
        data_o <= rx_i.data;
    end

    always_ff @(posedge clk12_i) begin
        if (!rst_n_i) begin
            got_start_o    <= 1'b0;
            token_o        <= 2'b00;
            byte_is_data_o <= 1'b0;
            data_valid_o   <= 1'b0;
            pid_wait_q     <= 1'b0;
            in_packet_q    <= 1'b0;
        end else begin
            data_valid_o   <= rx_i.valid;
            got_start_o    <= rx_i.valid && expect_pid;
            // Only bytes after the PID and inside an open packet count as data
            byte_is_data_o <= rx_i.valid && !expect_pid && in_packet_q;
            pid_wait_q     <= expect_pid && !rx_i.valid;
            if (rx_i.valid && expect_pid) begin
                // Keep the toggle carrying PID bits until the next start
                token_o     <= rx_i.data[DATA_TOGGLE_BIT -: 2];
                // A PID with eop is a zero length packet and never opens
                in_packet_q <= !rx_i.eop;
            end else if (rx_i.eop) begin
                in_packet_q <= 1'b0;
            end
        end
    end

    // The SIE must close a packet before it announces the next one
    assert property (@(posedge clk12_i) disable iff (!rst_n_i)
        pkt_start_i |-> !in_packet_q && !pid_wait_q)
        else $error("packet start while previous packet still open");

endmodule

`default_nettype wire

// File: hdl/trans_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module trans_fifo #(
    parameter int ADDR_WID = 4
)(
    input  logic                   clk12_i,
    input  logic                   rst_n_i,

    // Fill side
    input  logic                   wr_i,
    input  logic [7:0]             wr_data_i,
    input  usb_ep_pkg::fill_ctrl_t fill_i,
    output logic                   full_o,

    // Pop side
    input  usb_ep_pkg::pop_ctrl_t  pop_i,
    output logic                   data_avail_o,
    output logic [7:0]             data_o
);

    localparam int DEPTH = 2 ** ADDR_WID;

    logic [7:0] mem [DEPTH];

    // Pointers carry one extra wrap bit so full and empty can be told apart
    // The working pointers move per byte, the committed ones per transaction
    logic [ADDR_WID:0] wr_ptr_q;
    logic [ADDR_WID:0] wr_commit_q;
    logic [ADDR_WID:0] rd_ptr_q;
    logic [ADDR_WID:0] rd_commit_q;
    logic [ADDR_WID:0] wr_ptr_next;
    logic [ADDR_WID:0] rd_ptr_next;

    logic wr_accept;
    logic pop_accept;
    logic data_avail_q;

    // Bytes in flight on each side, only watched by the checks below
    logic [ADDR_WID:0] fill_level;
    logic [ADDR_WID:0] unread_level;

    // Full when the writer has lapped the last committed read position
    // Bytes popped in an open pop transaction are not free yet
    assign full_o = (wr_ptr_q[ADDR_WID] != rd_commit_q[ADDR_WID]) &&
                    (wr_ptr_q[ADDR_WID-1:0] == rd_commit_q[ADDR_WID-1:0]);

    assign wr_accept    = wr_i && !full_o;
    assign pop_accept   = pop_i.pop && data_avail_q;
    assign data_avail_o = data_avail_q;

    // Next working write pointer, a failed fill drops everything since the last commit
    always_comb begin
        wr_ptr_next = wr_ptr_q + {{ADDR_WID{1'b0}}, wr_accept};
        if (fill_i.done && !fill_i.success) begin
            wr_ptr_next = wr_commit_q;
        end
    end

    // Next working read pointer, a failed pop transaction rewinds to its start
    always_comb begin
        rd_ptr_next = rd_ptr_q + {{ADDR_WID{1'b0}}, pop_accept};
        if (pop_i.done && !pop_i.success) begin
            rd_ptr_next = rd_commit_q;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (!rst_n_i) begin
            wr_ptr_q     <= '0;
            wr_commit_q  <= '0;
            rd_ptr_q     <= '0;
            rd_commit_q  <= '0;
            data_avail_q <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_next;
            rd_ptr_q <= rd_ptr_next;
            // A commit takes the byte written in the same cycle along
            if (fill_i.done && fill_i.success) begin
                wr_commit_q <= wr_ptr_next;
            end
            if (pop_i.done && pop_i.success) begin
                rd_commit_q <= rd_ptr_next;
            end
            // Sees the committed write pointer one cycle late, so new data
            // shows two cycles after the done strobe while pops act at once
            data_avail_q <= rd_ptr_next != wr_commit_q;
        end
    end

    // Block RAM style storage with a registered read port
    // Reading at the next pointer keeps data_o lined up with rd_ptr_q
    always_ff @(posedge clk12_i) begin
        if (wr_accept) begin
            mem[wr_ptr_q[ADDR_WID-1:0]] <= wr_data_i;
        end
        data_o <= mem[rd_ptr_next[ADDR_WID-1:0]];
    end

    assign fill_level   = wr_ptr_q - rd_commit_q;
    assign unread_level = wr_commit_q - rd_ptr_q;

    // No write while full, so the writer never overruns unreleased bytes
    assert property (@(posedge clk12_i) disable iff (!rst_n_i)
        fill_level <= DEPTH)
        else $error("write side overran the committed read pointer");

    // No pop without data, so the reader never passes the committed writes
    assert property (@(posedge clk12_i) disable iff (!rst_n_i)
        unread_level <= DEPTH)
        else $error("read side passed the committed write pointer");

endmodule

`default_nettype wire

// File: hdl/usb_endpoint_in.sv
`timescale 1ns/1ps
`default_nettype none

module usb_endpoint_in #(
    parameter usb_ep_pkg::endpoint_config_t EP_CONF = usb_ep_pkg::EP_CONF_DEFAULT
)(
    input  logic                   clk12_i,
    input  logic                   rst_n_i,
    input  logic                   got_start_i,
    input  logic [1:0]             token_i,
    input  logic                   byte_is_data_i,
    input  logic [7:0]             data_i,
    input  logic                   data_valid_i,
    input  usb_ep_pkg::fill_ctrl_t fill_i,
    input  logic                   config_event_i,
    output logic                   full_o,
    input  usb_ep_pkg::pop_ctrl_t  pop_i,
    output logic                   data_avail_o,
    output logic [7:0]             data_o,
    output usb_ep_pkg::ep_resp_t   resp_o
);
    import usb_ep_pkg::*;

    // High for the whole packet when it is a repeat of one already stored
    logic ignore_pkt;
    logic fifo_wr;

    generate
        if (EP_CONF.ep_type == ISOCHRONOUS) begin : g_iso
            // Isochronous data has no retries, every packet is taken
            assign ignore_pkt = 1'b0;
        end else begin : g_toggle
            logic expected_toggle_q;

            always_ff @(posedge clk12_i) begin
                if (!rst_n_i) begin
                    ignore_pkt        <= 1'b0;
                    expected_toggle_q <= 1'b0;
                end else begin
                    // Decided once per packet, before the first data byte arrives
                    if (got_start_i) begin
                        ignore_pkt <= token_i[DATA_TOGGLE_BIT-2] != expected_toggle_q;
                    end
                    // A configuration event restarts the sequence at DATA0
                    if (config_event_i) begin
                        expected_toggle_q <= 1'b0;
                    end else if (fill_i.done && fill_i.success && !ignore_pkt) begin
                        expected_toggle_q <= !expected_toggle_q;
                    end
                end
            end
        end
    endgenerate

    // Only payload bytes of a packet we want end up in the FIFO
    assign fifo_wr = data_valid_i && byte_is_data_i && !ignore_pkt;

    trans_fifo #(
        .ADDR_WID(int'(EP_CONF.addr_wid))
    ) u_fifo (
        .clk12_i     (clk12_i),
        .rst_n_i     (rst_n_i),
        .wr_i        (fifo_wr),
        .wr_data_i   (data_i),
        .fill_i      (fill_i),
        .full_o      (full_o),
        .pop_i       (pop_i),
        .data_avail_o(data_avail_o),
        .data_o      (data_o)
    );

    // A repeated packet is also ACKed so the host moves on
    assign resp_o = '{valid: 1'b1, pid: PID_ACK};

endmodule

`default_nettype wire

// File: hdl/usb_ep_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module usb_ep_subsys_top #(
    parameter usb_ep_pkg::endpoint_config_t EP_CONF = usb_ep_pkg::EP_CONF_DEFAULT
)(
    input  logic                   clk12_i,
    input  logic                   rst_n_i,
    input  usb_ep_pkg::rx_byte_t   rx_i,
    input  logic                   pkt_start_i,
    input  usb_ep_pkg::fill_ctrl_t fill_i,
    input  logic                   config_event_i,
    input  usb_ep_pkg::pop_ctrl_t  pop_i,
    output logic                   data_avail_o,
    output logic [7:0]             data_o,
    output logic                   full_o,
    output usb_ep_pkg::ep_resp_t   resp_o
);

    // Tracker outputs, all one cycle behind rx_i
    logic       got_start;
    logic [1:0] token;
    logic       byte_is_data;
    logic [7:0] rx_data;
    logic       rx_data_valid;

    usb_packet_tracker u_tracker (
        .clk12_i       (clk12_i),
        .rst_n_i       (rst_n_i),
        .rx_i          (rx_i),
        .pkt_start_i   (pkt_start_i),
        .got_start_o   (got_start),
        .token_o       (token),
        .byte_is_data_o(byte_is_data),
        .data_o        (rx_data),
        .data_valid_o  (rx_data_valid)
    );

    // Fill and pop controls go straight in, only the byte stream is delayed
    usb_endpoint_in #(
        .EP_CONF(EP_CONF)
    ) u_endpoint (
        .clk12_i       (clk12_i),
        .rst_n_i       (rst_n_i),
        .got_start_i   (got_start),
        .token_i       (token),
        .byte_is_data_i(byte_is_data),
        .data_i        (rx_data),
        .data_valid_i  (rx_data_valid),
        .fill_i        (fill_i),
        .config_event_i(config_event_i),
        .full_o        (full_o),
        .pop_i         (pop_i),
        .data_avail_o  (data_avail_o),
        .data_o        (data_o),
        .resp_o        (resp_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_usb_ep.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_ep;
    import usb_ep_pkg::*;

    localparam endpoint_config_t TB_CONF = '{ep_type: BULK, addr_wid: 4'd4};
    // ACK handshake PID nibble is 0010, sent with its ones complement in the upper nibble
    localparam logic [3:0] ACK_NIBBLE = 4'b0010;
    localparam ep_resp_t ACK_RESP = '{valid: 1'b1, pid: {~ACK_NIBBLE, ACK_NIBBLE}};
    localparam string TRACE_FILE = "testbench/usb_ep_trace.txt";
    localparam int CYCLES_PER_RECORD = 64;

    logic       clk12;
    logic       rst_n;
    rx_byte_t   rx;
    logic       pkt_start;
    fill_ctrl_t fill;
    logic       config_event;
    pop_ctrl_t  pop;
    logic       data_avail;
    logic [7:0] data;
    logic       full;
    ep_resp_t   resp;

    int fd;
    int n_records;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    logic in_test;
    logic [8*24-1:0] test_name;
    logic [8*8-1:0] tag;
    logic [8*256-1:0] line_buf;

    usb_ep_subsys_top #(
        .EP_CONF(TB_CONF)
    ) uut (
        .clk12_i       (clk12),
        .rst_n_i       (rst_n),
        .rx_i          (rx),
        .pkt_start_i   (pkt_start),
        .fill_i        (fill),
        .config_event_i(config_event),
        .pop_i         (pop),
        .data_avail_o  (data_avail),
        .data_o        (data),
        .full_o        (full),
        .resp_o        (resp)
    );

    // 8 ns period
    initial clk12 = 1'b0;
    always #4 clk12 = ~clk12;

    // Inputs change 1 ns after the rising edge, outputs are read at the same point
    task automatic next_cycle();
        @(posedge clk12);
        #1;
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAIL %0s: %0s expected %02h actual %02h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string what, input ep_resp_t exp, input ep_resp_t act);
        if (act !== exp) begin
            $display("FAIL %0s: %0s expected %03h actual %03h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0s: %0s expected %0b actual %0b", test_name, what, exp, act);
            errors++;
        end
    endtask

    // First pass over the trace so the watchdog knows how long the run may take
    task automatic count_records();
        int cfd;
        int rc;
        logic [8*8-1:0] tok;
        cfd = $fopen(TRACE_FILE, "r");
        if (cfd != 0) begin
            while ($fscanf(cfd, "%s", tok) == 1) begin
                if (tok != "#") n_records++;
                rc = $fgets(line_buf, cfd);
            end
            $fclose(cfd);
        end
    endtask

    // Prints the verdict line of the test that is open, if any
    task automatic finish_test();
        if (in_test) begin
            tests_run++;
            if (errors == test_errors) begin
                $display("test %0s: ok", test_name);
            end else begin
                tests_failed++;
                $display("test %0s: %0d check(s) wrong", test_name, errors - test_errors);
            end
        end
    endtask

    // PID with the start pulse, then the data bytes, eop on the last one
    // The fill done strobe follows right after the last byte
    task automatic send_packet();
        logic [7:0] pid;
        logic [7:0] b;
        int n;
        int ok;
        int rc;
        rc = $fscanf(fd, "%h %d", pid, n);
        rx = '{data: pid, valid: 1'b1, eop: (n == 0)};
        pkt_start = 1'b1;
        next_cycle();
        pkt_start = 1'b0;
        for (int i = 0; i < n; i++) begin
            rc = $fscanf(fd, "%h", b);
            rx = '{data: b, valid: 1'b1, eop: (i == n - 1)};
            next_cycle();
        end
        rc = $fscanf(fd, "%d", ok);
        rx = '0;
        fill = '{done: 1'b1, success: ok[0]};
        next_cycle();
        fill = '0;
        // Committed bytes show on data_avail_o two cycles after the strobe
        repeat (3) next_cycle();
        check_resp("resp_o", ACK_RESP, resp);
    endtask

    // Reads count bytes, each checked before its pop strobe, then ends the pop transaction
    task automatic pop_bytes();
        logic [7:0] exp;
        int n;
        int ok;
        int waited;
        int rc;
        rc = $fscanf(fd, "%d %d", n, ok);
        for (int i = 0; i < n; i++) begin
            rc = $fscanf(fd, "%h", exp);
            waited = 0;
            while (!data_avail && waited < 16) begin
                next_cycle();
                waited++;
            end
            if (!data_avail) begin
                $display("%0s: no data available for pop byte %0d", test_name, i);
                errors++;
            end else begin
                check_byte($sformatf("data_o at pop byte %0d", i), exp, data);
                pop = '{pop: 1'b1, done: 1'b0, success: 1'b0};
                next_cycle();
                pop = '0;
            end
        end
        pop = '{pop: 1'b0, done: 1'b1, success: ok[0]};
        next_cycle();
        pop = '0;
        next_cycle();
    endtask

    task automatic check_status();
        int avail;
        int fl;
        int rc;
        rc = $fscanf(fd, "%d %d", avail, fl);
        check_flag("data_avail_o", avail[0], data_avail);
        check_flag("full_o", fl[0], full);
    endtask

    task automatic pulse_config();
        config_event = 1'b1;
        next_cycle();
        config_event = 1'b0;
        next_cycle();
    endtask

    initial begin : main
        int rc;
        rx = '0;
        pkt_start = 1'b0;
        fill = '0;
        config_event = 1'b0;
        pop = '0;
        rst_n = 1'b0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        n_records = 0;
        in_test = 1'b0;
        test_name = "none";
        count_records();
        repeat (8) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("trace file %0s could not be opened", TRACE_FILE);
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                case (tag)
                    "#": rc = $fgets(line_buf, fd);
                    "T": begin
                        finish_test();
                        rc = $fscanf(fd, "%s", test_name);
                        test_errors = errors;
                        in_test = 1'b1;
                    end
                    "P": send_packet();
                    "Q": pop_bytes();
                    "S": check_status();
                    "C": pulse_config();
                    default: begin
                        $display("unknown record %0s in the trace", tag);
                        errors++;
                        rc = $fgets(line_buf, fd);
                    end
                endcase
            end
            finish_test();
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed, %0d wrong checks", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Ends a stuck run, allowing 64 cycles per trace record plus the reset
    initial begin : watchdog
        wait (n_records > 0);
        repeat (n_records * CYCLES_PER_RECORD + 16) @(posedge clk12);
        $display("watchdog expired before the trace of %0d records finished", n_records);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/usb_ep_trace.txt
# T name | P pid(hex) nbytes bytes(hex) success | Q count success expected(hex)
# S data_avail full | C pulses config_event_i
T data0_roundtrip
P C3 4 11 22 33 44 1
S 1 0
Q 4 1 11 22 33 44
S 0 0
T failed_fill
P 4B 3 A1 A2 A3 0
S 0 0
P 4B 2 B1 B2 1
Q 2 1 B1 B2
S 0 0
T repeat_data0
P C3 2 C1 C2 1
P C3 2 EE EF 1
P 4B 2 D1 D2 1
Q 4 1 C1 C2 D1 D2
S 0 0
T pop_replay
P C3 3 51 52 53 1
Q 3 0 51 52 53
Q 3 1 51 52 53
S 0 0
T fill_to_full
P 4B 16 80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F 1
S 1 1
Q 16 1 80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
S 0 0
T config_reset
P C3 1 61 1
Q 1 1 61
C
P C3 2 71 72 1
Q 2 1 71 72
S 0 0

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the endpoint testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_usb_ep -o tb_usb_ep > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_usb_ep > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

// File: project.f
hdl/usb_ep_pkg.sv
hdl/usb_packet_tracker.sv
hdl/trans_fifo.sv
hdl/usb_endpoint_in.sv
hdl/usb_ep_subsys_top.sv
testbench/tb_usb_ep.sv
